//--- filelist.f
verilog/disp_pkg.sv
verilog/timer_pkg.sv
verilog/time_if.sv
verilog/input_conditioner.sv
verilog/stopwatch_core.sv
verilog/display_scan.sv
verilog/stopwatch_top.sv
verification/stopwatch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the stopwatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module stopwatch_tb \
    -o stopwatch_sim > build.log 2>&1 \
    && ./obj_dir/stopwatch_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- verification/stopwatch_tb.sv
`timescale 1ns/1ps

module stopwatch_tb import disp_pkg::*, timer_pkg::*; ;

    localparam int TICK_DIV = 40;
    localparam int SCAN_DIV = 4;
    localparam int NUM_TESTS = 14;
    localparam int ACT_IDLE = 0;
    localparam int ACT_START = 1;
    localparam int ACT_CLEAR = 2;
    localparam int OVF = -1;            // expected value meaning four dashes
    localparam int LAST_SEC = ((MIN_HI_MAX * 10 + MIN_LO_MAX) * 60) + SEC_HI_MAX * 10 + SEC_LO_MAX;

    logic clk;
    logic reset;
    logic start_btn;
    logic clear_btn;
    logic [6:0] seg;
    logic [3:0] digit_en;

    string test_name [NUM_TESTS];
    int test_act [NUM_TESTS];
    int test_press [NUM_TESTS];
    int test_ticks [NUM_TESTS];
    int test_exp [NUM_TESTS];

    seg_t seen_seg [4];
    int seen_cnt [4];
    int errors = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    int base_sec = 0;                   // seconds banked by earlier runs
    int run_len = 0;                    // cycles since the current run began
    bit running = 0;
    bit ovf_model = 0;

    stopwatch_top #(
        .TICK_DIV(TICK_DIV),
        .SCAN_DIV(SCAN_DIV)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .start_btn(start_btn),
        .clear_btn(clear_btn),
        .seg      (seg),
        .digit_en (digit_en)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // active-low a..g, a is bit 6
    function automatic seg_t seg_pattern(input int code);
        case (code)
            0:       return 7'b000_0001;
            1:       return 7'b100_1111;
            2:       return 7'b001_0010;
            3:       return 7'b000_0110;
            4:       return 7'b100_1100;
            5:       return 7'b010_0100;
            6:       return 7'b010_0000;
            7:       return 7'b000_1111;
            8:       return 7'b000_0000;
            9:       return 7'b000_0100;
            11:      return 7'b111_1110;  // dash
            default: return 7'b111_1111;
        endcase
    endfunction

    task automatic add_test(input int idx, input string name, input int act,
                            input int press, input int ticks, input int exp);
        test_name[idx] = name;
        test_act[idx] = act;
        test_press[idx] = press;
        test_ticks[idx] = ticks;
        test_exp[idx] = exp;
    endtask

    task automatic load_table();
        add_test(0,  "after_reset",  ACT_IDLE,  0,   1,    0);
        add_test(1,  "count_75",     ACT_START, 3,   75,   75);
        add_test(2,  "stop_idle",    ACT_START, 3,   20,   75);
        add_test(3,  "resume",       ACT_START, 3,   50,   125);
        add_test(4,  "stop_again",   ACT_START, 3,   10,   125);
        add_test(5,  "run_more",     ACT_START, 3,   30,   155);
        add_test(6,  "clear_run",    ACT_CLEAR, 3,   5,    0);
        add_test(7,  "clear_idle",   ACT_IDLE,  0,   10,   0);
        add_test(8,  "held_start",   ACT_START, 200, 10,   15);
        add_test(9,  "held_stop",    ACT_START, 3,   5,    15);
        add_test(10, "clear_again",  ACT_CLEAR, 3,   1,    0);
        add_test(11, "overflow",     ACT_START, 3,   3600, OVF);
        add_test(12, "ovf_start",    ACT_START, 3,   2,    OVF);
        add_test(13, "ovf_clear",    ACT_CLEAR, 3,   2,    0);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // whole ticks of each run, banked at stop
    task automatic advance_model(input int act, input int len, output int exp);
        if (act == ACT_CLEAR) begin
            base_sec = 0;
            running = 0;
            ovf_model = 0;
            run_len = 0;
        end else if (act == ACT_START && !ovf_model) begin
            if (running) begin
                base_sec = base_sec + run_len / TICK_DIV;
                running = 0;
            end else begin
                running = 1;
                run_len = 0;
            end
        end
        if (running) begin
            run_len = run_len + len;
            if (base_sec + run_len / TICK_DIV > LAST_SEC) begin
                ovf_model = 1;
                running = 0;
            end
        end
        if (ovf_model) begin
            exp = OVF;
        end else begin
            exp = base_sec + (running ? run_len / TICK_DIV : 0);
        end
    endtask

    task automatic drive_action(input int act, input int press);
        start_btn = (act == ACT_START);
        clear_btn = (act == ACT_CLEAR);
        repeat (press) @(negedge clk);
        start_btn = 1'b0;
        clear_btn = 1'b0;
    endtask

    task automatic capture_display(input string name);
        int prev_idx;
        int idx;
        prev_idx = -1;
        for (int i = 0; i < 4; i++) begin
            seen_cnt[i] = 0;
        end
        repeat (8 * SCAN_DIV) begin
            @(negedge clk);
            if (!$onehot(digit_en)) begin
                errors++;
                $display("%s: digit enables not one-hot, digit_en=%b", name, digit_en);
            end else begin
                idx = $clog2(digit_en);
                if (prev_idx >= 0 && idx != prev_idx && idx != (prev_idx + 3) % 4) begin
                    errors++;
                    $display("%s: digit %0d lit after digit %0d, out of scan order",
                             name, idx, prev_idx);
                end
                seen_seg[idx] = seg;
                seen_cnt[idx]++;
                prev_idx = idx;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (seen_cnt[i] == 0) begin
                errors++;
                $display("%s: digit %0d was never lit", name, i);
            end
        end
    endtask

    task automatic check_reading(input string name, input int exp_sec);
        int want [4];
        int mins;
        int secs;
        if (exp_sec < 0) begin
            for (int i = 0; i < 4; i++) want[i] = 11;
        end else begin
            mins = exp_sec / 60;
            secs = exp_sec % 60;
            want[3] = (mins / 10 == 0) ? 10 : mins / 10;    // leading blank
            want[2] = mins % 10;
            want[1] = secs / 10;
            want[0] = secs % 10;
        end
        for (int i = 0; i < 4; i++) begin
            if (seen_cnt[i] > 0) begin
                check_value($sformatf("%s digit %0d", name, i),
                            int'(seg_pattern(want[i])), int'(seen_seg[i]));
            end
        end
    endtask

    initial begin
        int len;
        int total;
        int model_exp;
        start_btn = 1'b0;
        clear_btn = 1'b0;
        reset = 1'b0;
        load_table();
        total = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += test_press[i] + test_ticks[i] * TICK_DIV + TICK_DIV / 2;
        end
        cycle_limit = (total + 3700 * TICK_DIV) * 12 / 10;
        repeat (5) @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            len = test_press[i] + test_ticks[i] * TICK_DIV + TICK_DIV / 2;
            advance_model(test_act[i], len, model_exp);
            check_value({test_name[i], " table vs model"}, test_exp[i], model_exp);
            drive_action(test_act[i], test_press[i]);
            repeat (len - test_press[i] - 8 * SCAN_DIV) @(negedge clk);
            capture_display(test_name[i]);
            check_reading(test_name[i], model_exp);
        end
        $display("tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/disp_pkg.sv
package disp_pkg;

    typedef logic [3:0] digit_code_t;   // 0..9 numerals, then blank and dash
    typedef logic [6:0] seg_t;          // a..g, bit 6 is a, active low

    localparam int NUM_DIGITS = 4;

    localparam digit_code_t CODE_BLANK = 4'd10;
    localparam digit_code_t CODE_DASH  = 4'd11;

    localparam seg_t SEG_DARK = 7'b111_1111;

    // segment pattern for one digit code
    function automatic seg_t glyph(input digit_code_t code);
        seg_t pattern;
        case (code)
            4'd0:       pattern = 7'b000_0001;
            4'd1:       pattern = 7'b100_1111;
            4'd2:       pattern = 7'b001_0010;
            4'd3:       pattern = 7'b000_0110;
            4'd4:       pattern = 7'b100_1100;
            4'd5:       pattern = 7'b010_0100;
            4'd6:       pattern = 7'b010_0000;
            4'd7:       pattern = 7'b000_1111;
            4'd8:       pattern = 7'b000_0000;
            4'd9:       pattern = 7'b000_0100;
            CODE_BLANK: pattern = SEG_DARK;
            CODE_DASH:  pattern = 7'b111_1110;  // g only
            default:    pattern = SEG_DARK;     // unused codes stay dark
        endcase
        return pattern;
    endfunction

endpackage

//--- verilog/display_scan.sv
`timescale 1ns/1ps

module display_scan import disp_pkg::*; #(
    parameter int SCAN_DIV = 6000
) (
    input  logic clk,
    input  logic reset,
    time_if.sink disp,
    output seg_t seg,
    output logic [3:0] digit_en
);

    localparam int SW = (SCAN_DIV > 2) ? $clog2(SCAN_DIV) : 1;
    localparam logic [SW-1:0] SCAN_LAST = SW'(SCAN_DIV - 1);

    logic [SW-1:0] scan_cnt;
    logic [1:0] digit_idx;      // 0 is min_hi, 3 is sec_lo
    digit_code_t cur_code;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == SCAN_LAST) begin
            scan_cnt <= '0;
            if (digit_idx == 2'(NUM_DIGITS - 1)) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 2'd1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        case (digit_idx)
            2'd0:    cur_code = disp.min_hi;
            2'd1:    cur_code = disp.min_lo;
            2'd2:    cur_code = disp.sec_hi;
            default: cur_code = disp.sec_lo;
        endcase
    end

    // outputs lag the selected code by one cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            seg      <= SEG_DARK;
            digit_en <= '0;
        end else begin
            seg      <= glyph(cur_code);
            digit_en <= 4'b1000 >> digit_idx;
        end
    end

    // enable holds or steps one digit to the right, wrapping to min_hi
    digit_en_onehot: assert property (
        @(posedge clk) disable iff (!reset)
        $past(reset, 2) |-> $onehot(digit_en) &&
            (digit_en == $past(digit_en) ||
             digit_en == {$past(digit_en[0]), $past(digit_en[3:1])})
    );

endmodule

//--- verilog/input_conditioner.sv
`timescale 1ns/1ps

module input_conditioner #(
    parameter int TICK_DIV = 50000000
) (
    input  logic clk,
    input  logic reset,
    input  logic start_btn,
    input  logic clear_btn,
    input  logic run,
    output logic start_pulse,
    output logic clear_pulse,
    output logic tick
);

    localparam int TW = (TICK_DIV > 2) ? $clog2(TICK_DIV) : 1;
    localparam logic [TW-1:0] TICK_LAST = TW'(TICK_DIV - 1);

    logic [1:0] btn_meta;       // bit 1 start, bit 0 clear
    logic [1:0] btn_sync;
    logic [1:0] btn_prev;
    logic [1:0] btn_pulse;
    logic [TW-1:0] tick_cnt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            btn_meta  <= '0;
            btn_sync  <= '0;
            btn_prev  <= '0;
            btn_pulse <= '0;
        end else begin
            btn_meta  <= {start_btn, clear_btn};
            btn_sync  <= btn_meta;
            btn_prev  <= btn_sync;
            btn_pulse <= btn_sync & ~btn_prev;  // one cycle per press
        end
    end

    assign start_pulse = btn_pulse[1];
    assign clear_pulse = btn_pulse[0];

    // prescaler sits at zero while stopped
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tick_cnt <= '0;
        end else if (!run || tick_cnt == TICK_LAST) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = run && (tick_cnt == TICK_LAST);

    // run must already have been high a cycle before any tick
    tick_after_run: assert property (
        @(posedge clk) disable iff (!reset)
        tick |-> $past(run)
    );

endmodule

//--- verilog/stopwatch_core.sv
`timescale 1ns/1ps

module stopwatch_core import disp_pkg::*, timer_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic start_pulse,
    input  logic clear_pulse,
    input  logic tick,
    output logic run,
    time_if.source disp
);

    logic overflow;
    logic at_limit;
    bcd_t sec_lo;
    bcd_t sec_hi;
    bcd_t min_lo;
    bcd_t min_hi;

    assign at_limit = (sec_lo == SEC_LO_MAX) && (sec_hi == SEC_HI_MAX) &&
                      (min_lo == MIN_LO_MAX) && (min_hi == MIN_HI_MAX);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            run      <= 1'b0;
            overflow <= 1'b0;
            sec_lo   <= '0;
            sec_hi   <= '0;
            min_lo   <= '0;
            min_hi   <= '0;
        end else if (clear_pulse) begin      // clear beats start
            run      <= 1'b0;
            overflow <= 1'b0;
            sec_lo   <= '0;
            sec_hi   <= '0;
            min_lo   <= '0;
            min_hi   <= '0;
        end else begin
            if (start_pulse && !overflow) begin
                run <= ~run;
            end
            if (tick) begin
                if (at_limit) begin
                    overflow <= 1'b1;       // 59:59 plus one
                    run      <= 1'b0;
                end else if (sec_lo != SEC_LO_MAX) begin
                    sec_lo <= sec_lo + 4'd1;
                end else begin
                    sec_lo <= '0;
                    if (sec_hi != SEC_HI_MAX) begin
                        sec_hi <= sec_hi + 4'd1;
                    end else begin
                        sec_hi <= '0;
                        if (min_lo != MIN_LO_MAX) begin
                            min_lo <= min_lo + 4'd1;
                        end else begin
                            min_lo <= '0;
                            min_hi <= min_hi + 4'd1;
                        end
                    end
                end
            end
        end
    end

    assign disp.sec_lo = overflow ? CODE_DASH : digit_code_t'(sec_lo);
    assign disp.sec_hi = overflow ? CODE_DASH : digit_code_t'(sec_hi);
    assign disp.min_lo = overflow ? CODE_DASH : digit_code_t'(min_lo);
    assign disp.min_hi = overflow      ? CODE_DASH :
                         (min_hi == '0) ? CODE_BLANK : digit_code_t'(min_hi);

    bcd_in_range: assert property (
        @(posedge clk) disable iff (!reset)
        (sec_lo <= SEC_LO_MAX) && (sec_hi <= SEC_HI_MAX) &&
        (min_lo <= MIN_LO_MAX) && (min_hi <= MIN_HI_MAX)
    );

endmodule

//--- verilog/stopwatch_top.sv
`timescale 1ns/1ps

module stopwatch_top #(
    parameter int TICK_DIV = 50000000,
    parameter int SCAN_DIV = 6000
) (
    input  logic clk,
    input  logic reset,
    input  logic start_btn,
    input  logic clear_btn,
    output logic [6:0] seg,
    output logic [3:0] digit_en
);

    logic start_pulse;
    logic clear_pulse;
    logic tick;
    logic run;

    time_if disp_bus ();

    input_conditioner #(
        .TICK_DIV(TICK_DIV)
    ) u_input (
        .clk        (clk),
        .reset      (reset),
        .start_btn  (start_btn),
        .clear_btn  (clear_btn),
        .run        (run),
        .start_pulse(start_pulse),
        .clear_pulse(clear_pulse),
        .tick       (tick)
    );

    stopwatch_core u_core (
        .clk        (clk),
        .reset      (reset),
        .start_pulse(start_pulse),
        .clear_pulse(clear_pulse),
        .tick       (tick),
        .run        (run),
        .disp       (disp_bus.source)
    );

    display_scan #(
        .SCAN_DIV(SCAN_DIV)
    ) u_scan (
        .clk     (clk),
        .reset   (reset),
        .disp    (disp_bus.sink),
        .seg     (seg),
        .digit_en(digit_en)
    );

endmodule

//--- verilog/time_if.sv
`timescale 1ns/1ps

interface time_if import disp_pkg::*; ();

    digit_code_t sec_lo;
    digit_code_t sec_hi;
    digit_code_t min_lo;
    digit_code_t min_hi;    // leftmost digit

    modport source (
        output sec_lo, sec_hi, min_lo, min_hi
    );

    modport sink (
        input sec_lo, sec_hi, min_lo, min_hi
    );

endinterface

//--- verilog/timer_pkg.sv
package timer_pkg;

    typedef logic [3:0] bcd_t;

    // highest value each digit reaches before it carries
    localparam bcd_t SEC_LO_MAX = 4'd9;
    localparam bcd_t SEC_HI_MAX = 4'd5;
    localparam bcd_t MIN_LO_MAX = 4'd9;
    localparam bcd_t MIN_HI_MAX = 4'd5;

endpackage
